/* Makefile */
TOP := card_table_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f logic/*.sv test/*.sv
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

# a failing check ends in $fatal, so the simulator exit status is the result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)
	verilator --lint-only -f sim.f --top-module card_table

clean:
	rm -rf obj_dir

/* logic/card_decode.sv */
`timescale 1ns/1ns

module card_decode
    import card_game_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      draw,
    input  logic      draw_player,
    input  card_raw_t rnd,
    output color_t    color,
    output number_t   number,
    output logic      card_player,
    output logic      card_valid
);

    color_t  color_nxt;
    number_t number_nxt;

    // upper two bits mod 3 plus 1, lower three bits mod 5
    always_comb begin
        color_nxt  = color_t'(rnd[4:3] % 2'd3) + color_t'(1);
        number_nxt = number_t'(rnd[2:0] % 3'd5);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            color       <= '0;
            number      <= '0;
            card_player <= 1'b0;
            card_valid  <= 1'b0;
        end else begin
            card_valid <= draw;
            if (draw) begin
                color       <= color_nxt;
                number      <= number_nxt;
                card_player <= draw_player;
            end
        end
    end

endmodule

/* logic/card_game_pkg.sv */
package card_game_pkg;

    // keypad code as sampled from the 4-bit pad
    typedef logic [3:0] key_t;

    // completed turns, wraps at 256
    typedef logic [7:0] count_t;

    // raw draw straight out of the shift register
    typedef logic [4:0] card_raw_t;

    // card color, legal values 1 to 3
    typedef logic [1:0] color_t;

    // card number, legal values 0 to 4
    typedef logic [2:0] number_t;

    // whose turn it is; TURN_P2 also drives the whose output
    typedef enum logic {
        TURN_P1 = 1'b0,
        TURN_P2 = 1'b1
    } turn_state_t;

endpackage

/* logic/card_lfsr.sv */
`timescale 1ns/1ns

module card_lfsr
    import card_game_pkg::*;
#(
    parameter card_raw_t LFSR_SEED = 5'b11100
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      draw,
    output card_raw_t rnd
);

    card_raw_t q;
    card_raw_t q_nxt;

    // taps 4 and 2 give the full 31-state period
    always_comb begin
        q_nxt    = q << 1;
        q_nxt[0] = q[4] ^ q[2];
    end

    // advances only on a draw, so the card order depends on the draw count alone
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            q <= LFSR_SEED; // must not be zero or the register locks up
        end else if (draw) begin
            q <= q_nxt;
        end
    end

    assign rnd = q; // decode samples this before the step takes effect

endmodule

/* logic/card_router.sv */
`timescale 1ns/1ns

module card_router
    import card_game_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    card_valid,
    input  logic    card_player,
    input  color_t  color,
    input  number_t number,
    output color_t  p1_color,
    output color_t  p2_color,
    output number_t p1_number,
    output number_t p2_number,
    output logic    p1_valid,
    output logic    p2_valid,
    output logic    match
);

    color_t  p1_color_nxt;
    color_t  p2_color_nxt;
    number_t p1_number_nxt;
    number_t p2_number_nxt;
    logic    p1_valid_nxt;
    logic    p2_valid_nxt;
    logic    match_nxt;

    // new card replaces the owner's previous one
    always_comb begin
        p1_color_nxt  = p1_color;
        p2_color_nxt  = p2_color;
        p1_number_nxt = p1_number;
        p2_number_nxt = p2_number;
        p1_valid_nxt  = p1_valid;
        p2_valid_nxt  = p2_valid;
        if (card_valid) begin
            if (card_player) begin
                p2_color_nxt  = color;
                p2_number_nxt = number;
                p2_valid_nxt  = 1'b1;
            end else begin
                p1_color_nxt  = color;
                p1_number_nxt = number;
                p1_valid_nxt  = 1'b1;
            end
        end
        // taken from the next slot contents so match moves with the slot
        match_nxt = p1_valid_nxt && p2_valid_nxt && (p1_number_nxt == p2_number_nxt);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            p1_color  <= '0;
            p2_color  <= '0;
            p1_number <= '0;
            p2_number <= '0;
            p1_valid  <= 1'b0;
            p2_valid  <= 1'b0;
            match     <= 1'b0;
        end else begin
            p1_color  <= p1_color_nxt;
            p2_color  <= p2_color_nxt;
            p1_number <= p1_number_nxt;
            p2_number <= p2_number_nxt;
            p1_valid  <= p1_valid_nxt; // stays set once the first card arrives
            p2_valid  <= p2_valid_nxt;
            match     <= match_nxt;
        end
    end

endmodule

/* logic/card_table.sv */
`timescale 1ns/1ns

module card_table
    import card_game_pkg::*;
#(
    parameter key_t      KEY_END_P1 = 4'h3,
    parameter key_t      KEY_END_P2 = 4'h1,
    parameter card_raw_t LFSR_SEED  = 5'b11100
) (
    input  logic    clk,
    input  logic    rst,
    input  key_t    keypad,
    output logic    whose,
    output logic    p1_valid,
    output logic    p2_valid,
    output logic    match,
    output count_t  turn_count,
    output color_t  p1_color,
    output color_t  p2_color,
    output number_t p1_number,
    output number_t p2_number
);

    logic      draw;
    logic      draw_player;
    card_raw_t rnd;
    color_t    color;
    number_t   number;
    logic      card_player;
    logic      card_valid;

    turn_control #(
        .KEY_END_P1 (KEY_END_P1),
        .KEY_END_P2 (KEY_END_P2)
    ) u_turn_control (
        .clk         (clk),
        .rst         (rst),
        .keypad      (keypad),
        .draw        (draw),
        .draw_player (draw_player),
        .whose       (whose),
        .turn_count  (turn_count)
    );

    card_lfsr #(
        .LFSR_SEED (LFSR_SEED)
    ) u_card_lfsr (
        .clk  (clk),
        .rst  (rst),
        .draw (draw),
        .rnd  (rnd)
    );

    card_decode u_card_decode (
        .clk         (clk),
        .rst         (rst),
        .draw        (draw),
        .draw_player (draw_player),
        .rnd         (rnd),
        .color       (color),
        .number      (number),
        .card_player (card_player),
        .card_valid  (card_valid)
    );

    card_router u_card_router (
        .clk         (clk),
        .rst         (rst),
        .card_valid  (card_valid),
        .card_player (card_player),
        .color       (color),
        .number      (number),
        .p1_color    (p1_color),
        .p2_color    (p2_color),
        .p1_number   (p1_number),
        .p2_number   (p2_number),
        .p1_valid    (p1_valid),
        .p2_valid    (p2_valid),
        .match       (match)
    );

endmodule

/* logic/turn_control.sv */
`timescale 1ns/1ns

module turn_control
    import card_game_pkg::*;
#(
    parameter key_t KEY_END_P1 = 4'h3,
    parameter key_t KEY_END_P2 = 4'h1
) (
    input  logic   clk,
    input  logic   rst,
    input  key_t   keypad,
    output logic   draw,
    output logic   draw_player,
    output logic   whose,
    output count_t turn_count
);

    turn_state_t state;
    turn_state_t state_nxt;
    logic        turn_end; // active player entered the end code

    // only the active player's code counts, the other one is ignored
    always_comb begin
        state_nxt = state;
        turn_end  = 1'b0;
        case (state)
            TURN_P1: begin
                if (keypad == KEY_END_P1) begin
                    turn_end  = 1'b1;
                    state_nxt = TURN_P2;
                end
            end
            TURN_P2: begin
                if (keypad == KEY_END_P2) begin
                    turn_end  = 1'b1;
                    state_nxt = TURN_P1;
                end
            end
            default: begin
                state_nxt = TURN_P1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= TURN_P1;
            draw        <= 1'b0;
            draw_player <= 1'b0;
            turn_count  <= '0;
        end else begin
            state <= state_nxt;
            draw  <= turn_end; // single cycle, the state has moved on by then
            if (turn_end) begin
                draw_player <= (state == TURN_P2); // the player who just finished
                turn_count  <= turn_count + count_t'(1);
            end
        end
    end

    // a held code cannot end two turns in a row since the compared code changes
    // with the state

    assign whose = (state == TURN_P2);

endmodule

/* sim.f */
logic/card_game_pkg.sv
logic/turn_control.sv
logic/card_lfsr.sv
logic/card_decode.sv
logic/card_router.sv
logic/card_table.sv
test/card_table_asserts.sv
test/card_table_tb.sv

/* test/card_table_asserts.sv */
`timescale 1ns/1ns

module card_table_asserts
    import card_game_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    draw,
    input logic    draw_player,
    input logic    whose,
    input logic    p1_valid,
    input logic    p2_valid,
    input color_t  p1_color,
    input color_t  p2_color,
    input number_t p1_number,
    input number_t p2_number
);

    // back-to-back draws must come from alternating players
    draw_alternates: assert property (@(posedge clk) disable iff (!rst)
        (draw && $past(draw)) |-> (draw_player != $past(draw_player)))
        else $error("two consecutive draws from player %0d", draw_player);

    // the turn flips on the same edge that raises draw
    whose_with_draw: assert property (@(posedge clk) disable iff (!rst)
        (whose != $past(whose)) |-> draw)
        else $error("whose changed without a draw");

    p1_color_legal: assert property (@(posedge clk) disable iff (!rst)
        p1_valid |-> (p1_color != color_t'(0)))
        else $error("player 1 slot holds color 0");

    p2_color_legal: assert property (@(posedge clk) disable iff (!rst)
        p2_valid |-> (p2_color != color_t'(0)))
        else $error("player 2 slot holds color 0");

    p1_number_legal: assert property (@(posedge clk) disable iff (!rst)
        p1_valid |-> (p1_number <= number_t'(4)))
        else $error("player 1 slot number %0d out of range", p1_number);

    p2_number_legal: assert property (@(posedge clk) disable iff (!rst)
        p2_valid |-> (p2_number <= number_t'(4)))
        else $error("player 2 slot number %0d out of range", p2_number);

endmodule

bind card_table card_table_asserts u_card_table_asserts (
    .clk         (clk),
    .rst         (rst),
    .draw        (draw),
    .draw_player (draw_player),
    .whose       (whose),
    .p1_valid    (p1_valid),
    .p2_valid    (p2_valid),
    .p1_color    (p1_color),
    .p2_color    (p2_color),
    .p1_number   (p1_number),
    .p2_number   (p2_number)
);

/* test/card_table_tb.sv */
`timescale 1ns/1ns

module card_table_tb
    import card_game_pkg::*;
();

    localparam key_t      END_P1   = 4'h3;
    localparam key_t      END_P2   = 4'h1;
    localparam key_t      KEY_IDLE = 4'h0;
    localparam card_raw_t SEED     = 5'b11100;

    // one keypad sample and the outputs expected after the edge that takes it
    typedef struct packed {
        key_t    key;
        logic    whose;
        count_t  count;
        logic    p1_valid;
        logic    p2_valid;
        color_t  p1_color;
        color_t  p2_color;
        number_t p1_number;
        number_t p2_number;
        logic    match;
    } row_t;

    logic    clk;
    logic    rst;
    key_t    keypad;
    logic    whose;
    logic    p1_valid;
    logic    p2_valid;
    logic    match;
    count_t  turn_count;
    color_t  p1_color;
    color_t  p2_color;
    number_t p1_number;
    number_t p2_number;

    row_t tbl[$];
    int   cycles = 0;
    int   cycle_limit = 0;
    logic saw_rise = 1'b0;
    logic saw_fall = 1'b0;

    // reference model state with index 0 for player 1
    logic      m_turn; // 1 while player 2 is up
    count_t    m_count;
    card_raw_t m_lfsr;
    logic      pend_valid [2];
    logic      pend_player[2];
    color_t    pend_color [2];
    number_t   pend_number[2];
    logic      s_valid [2];
    color_t    s_color [2];
    number_t   s_number[2];

    card_table #(
        .KEY_END_P1 (END_P1),
        .KEY_END_P2 (END_P2),
        .LFSR_SEED  (SEED)
    ) u_card_table (
        .clk        (clk),
        .rst        (rst),
        .keypad     (keypad),
        .whose      (whose),
        .p1_valid   (p1_valid),
        .p2_valid   (p2_valid),
        .match      (match),
        .turn_count (turn_count),
        .p1_color   (p1_color),
        .p2_color   (p2_color),
        .p1_number  (p1_number),
        .p2_number  (p2_number)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("TESTS FAILED");
        $fatal(1, "%s", what);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            report_failure($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            report_failure($sformatf("mismatch on %s", name));
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            report_failure($sformatf("mismatch on %s", name));
        end
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            report_failure($sformatf("mismatch on %s", name));
        end
    endtask

    task automatic check_number(input string name, input number_t exp, input number_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            report_failure($sformatf("mismatch on %s", name));
        end
    endtask

    function automatic card_raw_t lfsr_next(input card_raw_t v);
        return {v[3:0], v[4] ^ v[2]};
    endfunction

    function automatic color_t card_color(input card_raw_t raw);
        int top;
        top = int'(raw[4:3]);
        return color_t'(top % 3 + 1);
    endfunction

    function automatic number_t card_number(input card_raw_t raw);
        int low;
        low = int'(raw[2:0]);
        return number_t'(low % 5);
    endfunction

    function automatic key_t filler_key();
        key_t k;
        k = key_t'($urandom_range(15, 0));
        while (k == END_P1 || k == END_P2) begin
            k = key_t'($urandom_range(15, 0));
        end
        return k;
    endfunction

    task automatic model_reset();
        m_turn  = 1'b0;
        m_count = '0;
        m_lfsr  = SEED;
        for (int p = 0; p < 2; p++) begin
            pend_valid[p]  = 1'b0;
            pend_player[p] = 1'b0;
            pend_color[p]  = '0;
            pend_number[p] = '0;
            s_valid[p]     = 1'b0;
            s_color[p]     = '0;
            s_number[p]    = '0;
        end
    endtask

    // one clock edge of the game rules with cards landing two edges after the key
    task automatic model_step(input key_t key);
        logic ends;
        ends = (!m_turn && key == END_P1) || (m_turn && key == END_P2);
        if (pend_valid[1]) begin
            s_valid[pend_player[1]]  = 1'b1;
            s_color[pend_player[1]]  = pend_color[1];
            s_number[pend_player[1]] = pend_number[1];
        end
        pend_valid[1]  = pend_valid[0];
        pend_player[1] = pend_player[0];
        pend_color[1]  = pend_color[0];
        pend_number[1] = pend_number[0];
        pend_valid[0]  = ends;
        if (ends) begin
            pend_player[0] = m_turn;
            pend_color[0]  = card_color(m_lfsr);
            pend_number[0] = card_number(m_lfsr);
            m_lfsr         = lfsr_next(m_lfsr);
            m_turn         = !m_turn;
            m_count        = m_count + count_t'(1);
        end
    endtask

    task automatic add_row(input key_t key);
        row_t r;
        model_step(key);
        r.key       = key;
        r.whose     = m_turn;
        r.count     = m_count;
        r.p1_valid  = s_valid[0];
        r.p2_valid  = s_valid[1];
        r.p1_color  = s_color[0];
        r.p2_color  = s_color[1];
        r.p1_number = s_number[0];
        r.p2_number = s_number[1];
        r.match     = s_valid[0] && s_valid[1] && (s_number[0] == s_number[1]);
        tbl.push_back(r);
    endtask

    task automatic add_fillers(input int n);
        repeat (n) add_row(filler_key());
    endtask

    task automatic end_turn_row();
        add_row(m_turn ? END_P2 : END_P1);
    endtask

    task automatic build_table();
        model_reset();
        add_fillers(6);
        add_row(END_P2); // ignored in player 1's turn
        add_row(filler_key());
        add_row(END_P1);
        add_row(END_P1); // held code
        add_row(END_P1);
        add_row(END_P2);
        add_row(END_P2);
        add_row(END_P2);
        add_fillers(3);
        repeat (31) begin // one full LFSR period
            end_turn_row();
            add_fillers(int'($urandom_range(3, 1)));
        end
        repeat (4) begin // two draws in flight
            end_turn_row();
            end_turn_row();
            add_fillers(2);
        end
        repeat (270) begin
            end_turn_row();
            add_fillers(int'($urandom_range(2, 0)));
        end
        add_fillers(4); // drain the last cards
        cycle_limit = tbl.size() + 20;
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = tbl[i];
        check_flag("whose", r.whose, whose);
        check_count("turn_count", r.count, turn_count);
        check_flag("p1_valid", r.p1_valid, p1_valid);
        check_flag("p2_valid", r.p2_valid, p2_valid);
        check_color("p1_color", r.p1_color, p1_color);
        check_color("p2_color", r.p2_color, p2_color);
        check_number("p1_number", r.p1_number, p1_number);
        check_number("p2_number", r.p2_number, p2_number);
        check_flag("match", r.match, match);
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b0;
        keypad = KEY_IDLE;
        void'($urandom(32'h6c14));
        build_table();
        @(posedge clk);
        @(negedge clk);
        check_flag("whose", 1'b0, whose);
        check_count("turn_count", count_t'(0), turn_count);
        check_flag("match", 1'b0, match);
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        keypad <= tbl[0].key;
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            keypad <= (i + 1 < tbl.size()) ? tbl[i + 1].key : KEY_IDLE;
            @(negedge clk);
            check_row(i); // outputs after the edge that sampled row i
            if (i > 0 && tbl[i].match && !tbl[i - 1].match) saw_rise = 1'b1;
            if (i > 0 && !tbl[i].match && tbl[i - 1].match) saw_fall = 1'b1;
        end
        if (!saw_rise || !saw_fall) begin
            report_failure("match flag never rose and fell during the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
